// File: filelist.f
src/ldpc_pkg.sv
src/ldpc_frame_ifs.sv
src/ldpc_source.sv
src/ldpc_ibuffer.sv
src/ldpc_bitflip_engine.sv
src/ldpc_sink.sv
src/ldpc_dec_top.sv
verification/ldpc_dec_props.sv
verification/ldpc_dec_tb.sv

// File: run_sim.sh
#!/bin/sh
# verilator build and run of the decoder testbench, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ldpc_dec_tb \
  -f filelist.f -Mdir obj_dir -o ldpc_sim > build.log 2>&1 &&
  ./obj_dir/ldpc_sim > sim.log 2>&1
grep -q "Testbench passed" sim.log 2>/dev/null && echo "simulation passed" && exit 0 ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: src/ldpc_bitflip_engine.sv
// iterative 4x4 product-code bit-flip decoder with its FSM and both frame handshakes
`timescale 1ns/1ns

module ldpc_bitflip_engine (
  input  logic       iclkin,
  input  logic       rst_n,
  frame_if.eng_side  fr,
  result_if.eng_side res
);
  import ldpc_pkg::*;

  eng_state_t      state;
  cword_t          hd;         // word as loaded
  cword_t          wcw;        // working word
  cword_t          flipped;    // wcw after one pass
  tag_t            tag_q;
  niter_t          niter_q;
  niter_t          itc;        // passes done
  logic            fmode_q;
  logic [ROWS-1:0] row_fail;
  logic [COLS-1:0] col_fail;
  logic            all_pass;
  logic            done;
  err_t            err_q;
  logic            decfail_q;

  // differing positions between two words
  function automatic err_t count_diff(cword_t a, cword_t b);
    err_t   n;
    cword_t x;
    n = '0;
    x = a ^ b;
    for (int i = 0; i < FRAME_BITS; i++) begin
      n += err_t'(x[i]);
    end
    return n;
  endfunction

  // ----------------------------------------
  // checks on the working word
  // ----------------------------------------
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      row_fail[r] = wcw[DATA_BITS + r];          // row parity
      for (int c = 0; c < COLS; c++) begin
        row_fail[r] ^= wcw[r*COLS + c];
      end
    end
    for (int c = 0; c < COLS; c++) begin
      col_fail[c] = wcw[DATA_BITS + ROWS + c];   // column parity
      for (int r = 0; r < ROWS; r++) begin
        col_fail[c] ^= wcw[r*COLS + c];
      end
    end
  end

  assign all_pass = ~(|row_fail) & ~(|col_fail);
  assign done     = (itc == niter_q) || (fmode_q && all_pass);  // early stop only in fmode

  // flip rule, one pass
  always_comb begin
    flipped = wcw;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        flipped[r*COLS + c] = wcw[r*COLS + c] ^ (row_fail[r] & col_fail[c]);  // crossing
      end
    end
    if (col_fail == '0 && $onehot(row_fail)) begin
      flipped[DATA_BITS +: ROWS] = wcw[DATA_BITS +: ROWS] ^ row_fail;  // lone bad row parity
    end
    if (row_fail == '0 && $onehot(col_fail)) begin
      flipped[DATA_BITS+ROWS +: COLS] = wcw[DATA_BITS+ROWS +: COLS] ^ col_fail;
    end
  end

  // ----------------------------------------
  // FSM and handshakes
  // ----------------------------------------
  always_ff @(posedge iclkin) begin
    if (!rst_n) begin
      state   <= st_idle;
      itc     <= '0;
      fr.ack  <= 1'b0;
      res.req <= 1'b0;
    end else begin
      if (fr.ack && !fr.req) fr.ack <= 1'b0;     // phase 4 toward the buffer
      if (res.req && res.ack) res.req <= 1'b0;   // sink took the result
      case (state)
        st_idle: if (fr.req && !fr.ack) state <= st_load;
        st_load: begin
          fr.ack <= 1'b1;
          itc    <= '0;
          state  <= st_iterate;
        end
        st_iterate: begin
          if (done) state <= st_post;
          else itc <= itc + 1'b1;
        end
        st_post: state <= st_release;
        st_release: begin
          if (!res.req && !res.ack) begin          // slot empty, old handshake closed
            res.req <= 1'b1;
            state   <= st_idle;                    // next frame may load meanwhile
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge iclkin) begin
    case (state)
      st_load: begin
        hd      <= fr.cw;
        wcw     <= fr.cw;
        tag_q   <= fr.tag;
        niter_q <= fr.niter;
        fmode_q <= fr.fmode;
      end
      st_iterate: if (!done) wcw <= flipped;
      st_post: begin
        err_q     <= count_diff(wcw, hd);
        decfail_q <= ~all_pass;
      end
      st_release: begin
        if (!res.req && !res.ack) begin
          res.data    <= wcw[DATA_BITS-1:0];
          res.tag     <= tag_q;
          res.decfail <= decfail_q;
          res.err     <= err_q;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: src/ldpc_dec_top.sv
// decoder top: source, input buffer, bit-flip engine and sink joined by two handshake interfaces
`timescale 1ns/1ns

module ldpc_dec_top (
  input  logic              iclkin,
  input  logic              rst_n,
  // input side
  input  logic              ival,
  input  logic              isop,
  input  logic              ieop,
  input  ldpc_pkg::tag_t    itag,
  input  ldpc_pkg::niter_t  initer,
  input  logic              ifmode,
  input  ldpc_pkg::llr_t    illr,
  output logic              ordy,
  output logic              obusy,
  // output side
  input  logic              ireq,
  output logic              ofull,
  output logic              oval,
  output logic              osop,
  output logic              oeop,
  output ldpc_pkg::byte_t   odat,
  output ldpc_pkg::tag_t    otag,
  output logic              odecfail,
  output ldpc_pkg::err_t    oerr
);

  // ----------------------------------------
  // source to buffer wires
  // ----------------------------------------
  logic             wr_en;
  logic             wr_full;
  ldpc_pkg::cword_t wr_cw;
  ldpc_pkg::tag_t   wr_tag;
  ldpc_pkg::niter_t wr_niter;
  logic             wr_fmode;

  frame_if  fr  ();   // buffer -> engine
  result_if res ();   // engine -> sink

  ldpc_source u_source (
    .iclkin (iclkin), .rst_n (rst_n),
    .ival (ival), .isop (isop), .ieop (ieop),
    .itag (itag), .initer (initer), .ifmode (ifmode), .illr (illr),
    .wr_full (wr_full), .ordy (ordy), .obusy (obusy),
    .wr_en (wr_en), .wr_cw (wr_cw), .wr_tag (wr_tag),
    .wr_niter (wr_niter), .wr_fmode (wr_fmode)
  );

  ldpc_ibuffer u_ibuffer (
    .iclkin (iclkin), .rst_n (rst_n),
    .wr_en (wr_en), .wr_cw (wr_cw), .wr_tag (wr_tag),
    .wr_niter (wr_niter), .wr_fmode (wr_fmode), .wr_full (wr_full),
    .fr (fr)
  );

  ldpc_bitflip_engine u_engine (
    .iclkin (iclkin), .rst_n (rst_n), .fr (fr), .res (res)
  );

  ldpc_sink u_sink (
    .iclkin (iclkin), .rst_n (rst_n), .ireq (ireq), .res (res),
    .ofull (ofull), .oval (oval), .osop (osop), .oeop (oeop),
    .odat (odat), .otag (otag), .odecfail (odecfail), .oerr (oerr)
  );

endmodule

// File: src/ldpc_frame_ifs.sv
// frame_if (buffer to engine) and result_if (engine to sink), both four-phase req/ack
`timescale 1ns/1ns

interface frame_if;
  import ldpc_pkg::*;

  logic   req;    // bank offered, payload stable
  logic   ack;    // engine has its copy
  cword_t cw;     // hard decisions, 24 bits
  tag_t   tag;
  niter_t niter;  // iteration budget
  logic   fmode;  // early stop allowed

  modport buf_side (output req, cw, tag, niter, fmode, input ack);
  modport eng_side (input req, cw, tag, niter, fmode, output ack);
endinterface

interface result_if;
  import ldpc_pkg::*;

  logic   req;      // result waiting
  logic   ack;      // sink has copied it
  dword_t data;     // decoded data bits only
  tag_t   tag;
  logic   decfail;  // some check still failing
  err_t   err;      // flipped positions

  modport eng_side (output req, data, tag, decfail, err, input ack);
  modport snk_side (input req, data, tag, decfail, err, output ack);
endinterface

// File: src/ldpc_ibuffer.sv
// two-bank input frame buffer: write from the source, four-phase req/ack toward the engine
`timescale 1ns/1ns

module ldpc_ibuffer (
  input  logic             iclkin,
  input  logic             rst_n,
  input  logic             wr_en,
  input  ldpc_pkg::cword_t wr_cw,
  input  ldpc_pkg::tag_t   wr_tag,
  input  ldpc_pkg::niter_t wr_niter,
  input  logic             wr_fmode,
  output logic             wr_full,
  frame_if.buf_side        fr
);
  import ldpc_pkg::*;

  // bank storage
  cword_t     bank_cw    [2];
  tag_t       bank_tag   [2];
  niter_t     bank_niter [2];
  logic       bank_fmode [2];

  logic [1:0] full;  // per bank
  logic       wptr;  // bank the source fills next
  logic       rptr;  // bank offered to the engine

  assign wr_full = full[wptr];  // both full when this one is

  always_ff @(posedge iclkin) begin
    if (wr_en) begin
      bank_cw[wptr]    <= wr_cw;
      bank_tag[wptr]   <= wr_tag;
      bank_niter[wptr] <= wr_niter;
      bank_fmode[wptr] <= wr_fmode;
    end
  end

  // ----------------------------------------
  // flags, pointers and frame req
  // ----------------------------------------
  always_ff @(posedge iclkin) begin
    if (!rst_n) begin
      full   <= '0;
      wptr   <= 1'b0;
      rptr   <= 1'b0;
      fr.req <= 1'b0;
    end else begin
      if (wr_en) begin
        full[wptr] <= 1'b1;
        wptr       <= ~wptr;
      end
      if (fr.req && fr.ack) begin
        fr.req     <= 1'b0;                    // engine has its copy
        full[rptr] <= 1'b0;                    // bank free again
        rptr       <= ~rptr;
      end else if (!fr.req && !fr.ack && full[rptr]) begin
        fr.req <= 1'b1;                        // previous handshake fully closed
      end
    end
  end

  // read bank straight onto the interface, stable while req is up
  assign fr.cw    = bank_cw[rptr];
  assign fr.tag   = bank_tag[rptr];
  assign fr.niter = bank_niter[rptr];
  assign fr.fmode = bank_fmode[rptr];

endmodule

// File: src/ldpc_pkg.sv
// shared constants, vector typedefs and engine state enum for the product-code decoder
package ldpc_pkg;

  // ----------------------------------------
  // code geometry
  // ----------------------------------------
  localparam int LLR_W      = 4;                        // soft metric width
  localparam int ROWS       = 4;
  localparam int COLS       = 4;
  localparam int DATA_BITS  = ROWS * COLS;              // d[r][c] at 4r+c
  localparam int FRAME_BITS = DATA_BITS + ROWS + COLS;  // data, row par, col par

  // ----------------------------------------
  // port and result widths
  // ----------------------------------------
  localparam int BYTE_W     = 8;                        // output word
  localparam int TAG_W      = 4;
  localparam int ERR_W      = 5;                        // holds 0..24
  localparam int NITER_W    = 8;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic signed [LLR_W-1:0]      llr_t;          // sign bit is the hard decision
  typedef logic        [FRAME_BITS-1:0] cword_t;
  typedef logic        [DATA_BITS-1:0]  dword_t;
  typedef logic        [BYTE_W-1:0]     byte_t;
  typedef logic        [TAG_W-1:0]      tag_t;
  typedef logic        [ERR_W-1:0]      err_t;
  typedef logic        [NITER_W-1:0]    niter_t;
  typedef logic        [4:0]            cnt_t;          // source bit position 0..23

  // engine FSM
  typedef enum logic [2:0] {
    st_idle,     // waiting for a buffer req
    st_load,     // copy frame, raise ack
    st_iterate,  // one flip pass per cycle
    st_post,     // error count and fail flag
    st_release   // hand result to the sink
  } eng_state_t;

endpackage

// File: src/ldpc_sink.sv
// result holding register and two-byte serializer toward the output port
`timescale 1ns/1ns

module ldpc_sink (
  input  logic              iclkin,
  input  logic              rst_n,
  input  logic              ireq,
  result_if.snk_side        res,
  output logic              ofull,
  output logic              oval,
  output logic              osop,
  output logic              oeop,
  output ldpc_pkg::byte_t   odat,
  output ldpc_pkg::tag_t    otag,
  output logic              odecfail,
  output ldpc_pkg::err_t    oerr
);
  import ldpc_pkg::*;

  dword_t data_q;     // held frame
  tag_t   tag_q;
  logic   decfail_q;
  err_t   err_q;
  logic   hi;         // next word is bits 15:8
  logic   take;       // copy a result this cycle
  logic   send;       // emit a word this cycle

  assign take = res.req && !res.ack && !ofull;
  assign send = ireq && ofull;

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge iclkin) begin
    if (!rst_n) begin
      ofull   <= 1'b0;
      hi      <= 1'b0;
      oval    <= 1'b0;
      osop    <= 1'b0;
      oeop    <= 1'b0;
      res.ack <= 1'b0;
    end else begin
      oval <= send;
      osop <= send & ~hi;                        // low byte first
      oeop <= send & hi;
      if (take) begin
        res.ack <= 1'b1;
        ofull   <= 1'b1;
        hi      <= 1'b0;
      end else if (res.ack && !res.req) begin
        res.ack <= 1'b0;                         // phase 4
      end
      if (send) begin
        hi <= ~hi;
        if (hi) ofull <= 1'b0;                   // second byte out, slot empty
      end
    end
  end

  // payload
  always_ff @(posedge iclkin) begin
    if (take) begin
      data_q    <= res.data;
      tag_q     <= res.tag;
      decfail_q <= res.decfail;
      err_q     <= res.err;
    end
    if (send) begin
      odat     <= hi ? data_q[BYTE_W +: BYTE_W] : data_q[0 +: BYTE_W];
      otag     <= tag_q;                         // repeated on both words
      odecfail <= decfail_q;
      oerr     <= err_q;
    end
  end

endmodule

// File: src/ldpc_source.sv
// input framing: llr accept, hard decision, bit packing, tag capture, frame write pulse
`timescale 1ns/1ns

module ldpc_source (
  input  logic              iclkin,
  input  logic              rst_n,
  input  logic              ival,
  input  logic              isop,
  input  logic              ieop,
  input  ldpc_pkg::tag_t    itag,
  input  ldpc_pkg::niter_t  initer,
  input  logic              ifmode,
  input  ldpc_pkg::llr_t    illr,
  input  logic              wr_full,
  output logic              ordy,
  output logic              obusy,
  output logic              wr_en,
  output ldpc_pkg::cword_t  wr_cw,
  output ldpc_pkg::tag_t    wr_tag,
  output ldpc_pkg::niter_t  wr_niter,
  output logic              wr_fmode
);
  import ldpc_pkg::*;

  logic acc;     // llr taken this cycle
  logic hd_bit;  // negative llr -> 1
  cnt_t cnt;     // position of the next bit

  assign acc    = ival & ordy;
  assign hd_bit = illr[LLR_W-1];

  // ready follows the write bank, low in reset
  always_ff @(posedge iclkin) begin
    if (!rst_n) begin
      ordy <= 1'b0;
    end else begin
      ordy <= ~wr_full;
    end
  end

  // ----------------------------------------
  // framing
  // ----------------------------------------
  always_ff @(posedge iclkin) begin
    if (!rst_n) begin
      obusy <= 1'b0;
      cnt   <= '0;
      wr_en <= 1'b0;
    end else begin
      wr_en <= 1'b0;                            // one cycle pulse
      if (acc && isop) begin                    // sop restarts framing
        obusy <= ~ieop;                         // sop with eop is too short, drop
        cnt   <= cnt_t'(1);
      end else if (acc && obusy) begin
        cnt <= cnt + 1'b1;
        if (cnt == cnt_t'(FRAME_BITS - 1)) begin
          obusy <= 1'b0;                        // 24th llr always ends the frame
          wr_en <= ieop;                        // kept only when eop sits on it
        end else if (ieop) begin
          obusy <= 1'b0;                        // short frame, dropped
        end
      end
    end
  end

  // packed word and per-frame settings
  always_ff @(posedge iclkin) begin
    if (acc && (isop || obusy)) begin
      wr_cw[isop ? cnt_t'(0) : cnt] <= hd_bit;
    end
    if (acc && isop) begin
      wr_tag   <= itag;
      wr_niter <= initer;
      wr_fmode <= ifmode;
    end
  end

endmodule

// File: verification/ldpc_dec_props.sv
// concurrent assertions on the top-level handshakes, the buffer write side and the frame request, bound to the top
`timescale 1ns/1ns

module ldpc_dec_props (
  input logic iclkin,
  input logic rst_n,
  input logic ofull,
  input logic oval,
  input logic osop,
  input logic oeop,
  input logic wr_en,
  input logic wr_full,
  input logic fr_req,
  input logic fr_ack
);

  // ----------------------------------------
  // output side
  // ----------------------------------------
  a_oval_needs_full: assert property (@(posedge iclkin) disable iff (!rst_n)
    oval |-> $past(ofull))
    else $error("oval without ofull on the previous cycle");

  a_markers_need_oval: assert property (@(posedge iclkin) disable iff (!rst_n)
    (osop || oeop) |-> oval)
    else $error("osop or oeop without oval");

  // ----------------------------------------
  // input side and buffer handoff
  // ----------------------------------------
  // ordy low must keep a finished frame out of a bank still in use
  a_no_bank_overrun: assert property (@(posedge iclkin) disable iff (!rst_n)
    wr_en |-> !wr_full)
    else $error("frame written into a full buffer bank");

  a_req_held: assert property (@(posedge iclkin) disable iff (!rst_n)
    (fr_req && !fr_ack) |=> fr_req)
    else $error("frame req dropped before ack");

endmodule

bind ldpc_dec_top ldpc_dec_props u_props (
  .iclkin (iclkin), .rst_n (rst_n),
  .ofull (ofull), .oval (oval), .osop (osop), .oeop (oeop),
  .wr_en (wr_en), .wr_full (wr_full),
  .fr_req (fr.req), .fr_ack (fr.ack)
);

// File: verification/ldpc_dec_tb.sv
// decoder testbench: clock, reset, reference model, lcg, compare task, collector, directed tests
`timescale 1ns/1ns

module ldpc_dec_tb;

  localparam int TOTAL_FRAMES = 19;                    // short frame included
  localparam int TIMEOUT_CYC  = 40 * TOTAL_FRAMES + 500;

  logic        iclkin;
  logic        rst_n;
  logic        ival, isop, ieop, ifmode, ireq;
  logic [3:0]  itag;
  logic [7:0]  initer;
  logic [3:0]  illr;
  logic        ordy, obusy, ofull, oval, osop, oeop, odecfail;
  logic [7:0]  odat;
  logic [3:0]  otag;
  logic [4:0]  oerr;

  logic [15:0] exp_data [$];                           // expected frames, oldest first
  logic [3:0]  exp_tag  [$];
  logic        exp_fail [$];
  logic [4:0]  exp_err  [$];
  int          frames_exp, frames_rcvd, cycles;
  logic        hi_word;                                // next word is bits 15:8
  logic        watch_ordy, saw_ordy_low;
  logic [31:0] lcg_state;

  ldpc_dec_top u_dut (.*);

  initial begin
    iclkin = 1'b0;
    forever #5 iclkin = ~iclkin;
  end

  // ----------------------------------------
  // reporting
  // ----------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // encode, add errors, then flip passes as the code rules say
  task automatic run_model(input logic [15:0] d, input logic [23:0] emask, input logic [7:0] n,
                           output logic [23:0] hd, output logic [15:0] dout,
                           output logic fail, output logic [4:0] nerr);
    logic [23:0] w;
    logic [3:0]  rf;
    logic [3:0]  cf;
    hd[15:0] = d;
    for (int r = 0; r < 4; r++) hd[16+r] = ^d[4*r +: 4];             // row parity
    for (int c = 0; c < 4; c++) hd[20+c] = d[c] ^ d[4+c] ^ d[8+c] ^ d[12+c];
    hd = hd ^ emask;                                                 // channel errors
    w  = hd;
    for (int it = 0; it <= n; it++) begin
      for (int r = 0; r < 4; r++) rf[r] = (^w[4*r +: 4]) ^ w[16+r];
      for (int c = 0; c < 4; c++) cf[c] = w[c] ^ w[4+c] ^ w[8+c] ^ w[12+c] ^ w[20+c];
      if (it == n) break;                                            // final checks only
      for (int r = 0; r < 4; r++)
        for (int c = 0; c < 4; c++)
          if (rf[r] && cf[c]) w[4*r+c] = ~w[4*r+c];
      if ($countones(cf) == 0 && $countones(rf) == 1) w[19:16] = w[19:16] ^ rf;
      if ($countones(rf) == 0 && $countones(cf) == 1) w[23:20] = w[23:20] ^ cf;
    end
    dout = w[15:0];
    fail = |{rf, cf};
    nerr = 5'($countones(w ^ hd));
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic drive_frame(input logic [23:0] hd, input logic [3:0] tag,
                             input logic [7:0] n, input logic fm, input int len);
    int i;
    i = 0;
    while (i < len) begin
      @(negedge iclkin);
      check_equal("obusy", obusy, i > 0);             // high between sop and eop
      ival   = 1'b1;
      isop   = (i == 0);
      ieop   = (i == len - 1);
      itag   = tag;
      initer = n;
      ifmode = fm;
      illr   = hd[i] ? 4'hB : 4'h5;                   // -5 or +5
      if (ordy) i++;                                  // taken at the coming edge
    end
  endtask

  task automatic queue_and_drive(input logic [15:0] d, input logic [23:0] emask,
                                 input logic [3:0] tag, input logic [7:0] n, input logic fm);
    logic [23:0] hd;
    logic [15:0] dout;
    logic        fail;
    logic [4:0]  nerr;
    run_model(d, emask, n, hd, dout, fail, nerr);
    exp_data.push_back(dout);
    exp_tag.push_back(tag);
    exp_fail.push_back(fail);
    exp_err.push_back(nerr);
    frames_exp++;
    drive_frame(hd, tag, n, fm, 24);
  endtask

  task automatic close_input();
    @(negedge iclkin);
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
  endtask

  task automatic wait_all_out();
    wait (frames_rcvd == frames_exp);                 // watchdog bounds this
    @(negedge iclkin);
  endtask

  // output collector, sampled mid-cycle
  always @(negedge iclkin) begin
    if (rst_n && oval) begin
      if (exp_data.size() == 0) begin
        fail_run("output word arrived with no frame expected");
      end else begin
        check_equal("osop", osop, !hi_word);
        check_equal("oeop", oeop, hi_word);
        check_equal("odat", odat, hi_word ? exp_data[0][15:8] : exp_data[0][7:0]);
        check_equal("otag", otag, exp_tag[0]);
        check_equal("odecfail", odecfail, exp_fail[0]);
        check_equal("oerr", oerr, exp_err[0]);
        if (hi_word) begin
          void'(exp_data.pop_front());
          void'(exp_tag.pop_front());
          void'(exp_fail.pop_front());
          void'(exp_err.pop_front());
          frames_rcvd++;
        end
        hi_word = ~hi_word;
      end
    end
    if (watch_ordy && !ordy) saw_ordy_low = 1'b1;
  end

  always @(posedge iclkin) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) fail_run("timeout, output frames did not arrive in time");
  end

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic check_clean_frame();
    queue_and_drive(16'hA5C3, 24'h0, 4'h3, 8'd4, 1'b0);
    close_input();
    wait_all_out();
  endtask

  task automatic correct_single_errors();
    queue_and_drive(16'h1234, 24'h000020, 4'h4, 8'd4, 1'b0);    // data bit 5
    queue_and_drive(16'hBEEF, 24'h020000, 4'h5, 8'd4, 1'b0);    // row 1 parity
    close_input();
    wait_all_out();
  endtask

  task automatic decode_double_error();
    queue_and_drive(16'h0F0F, 24'h000802, 4'h7, 8'd4, 1'b0);    // d[0][1], d[2][3]
    close_input();
    wait_all_out();
  endtask

  task automatic limit_iterations();
    queue_and_drive(16'h5AA5, 24'h000040, 4'h8, 8'd0, 1'b0);    // no passes at all
    queue_and_drive(16'h5AA5, 24'h000040, 4'h9, 8'd8, 1'b0);
    queue_and_drive(16'h5AA5, 24'h000040, 4'hA, 8'd8, 1'b1);    // early stop
    close_input();
    wait_all_out();
  endtask

  task automatic stall_output();
    logic [31:0] rnd;
    logic [23:0] emask;
    ireq       = 1'b0;
    watch_ordy = 1'b1;
    fork
      begin
        for (int k = 0; k < 10; k++) begin
          rnd   = lcg_next();
          emask = rnd[31] ? (24'd1 << (rnd[4:0] % 24)) : 24'd0;
          queue_and_drive(rnd[23:8], emask, 4'(k), 8'd3, rnd[30]);
        end
      end
      begin
        repeat (200) @(negedge iclkin);
        ireq = 1'b1;                                   // release the sink
      end
    join
    close_input();
    wait_all_out();
    watch_ordy = 1'b0;
    check_equal("ordy_dropped", saw_ordy_low, 1'b1);
    check_equal("ordy", ordy, 1'b1);
  endtask

  task automatic drop_short_frame();
    drive_frame(24'hFFFFFF, 4'hE, 8'd4, 1'b0, 20);   // eop on llr 20
    close_input();
    queue_and_drive(16'hC0DE, 24'h000100, 4'h6, 8'd4, 1'b0);
    close_input();
    wait_all_out();
    repeat (60) @(negedge iclkin);                    // nothing else may show up
  endtask

  initial begin
    rst_n        = 1'b0;
    ival         = 1'b0;
    isop         = 1'b0;
    ieop         = 1'b0;
    itag         = '0;
    initer       = '0;
    ifmode       = 1'b0;
    illr         = '0;
    ireq         = 1'b1;
    frames_exp   = 0;
    frames_rcvd  = 0;
    cycles       = 0;
    hi_word      = 1'b0;
    watch_ordy   = 1'b0;
    saw_ordy_low = 1'b0;
    lcg_state    = 32'h109;
    repeat (16) @(posedge iclkin);
    @(negedge iclkin);
    rst_n = 1'b1;
    @(negedge iclkin);
    check_equal("ordy", ordy, 1'b1);                  // up one cycle after reset
    check_equal("obusy", obusy, 1'b0);
    check_equal("ofull", ofull, 1'b0);
    check_equal("oval", oval, 1'b0);
    check_clean_frame();
    correct_single_errors();
    decode_double_error();
    limit_iterations();
    stall_output();
    drop_short_frame();
    if (frames_rcvd == frames_exp && exp_data.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run("frames missing at the end of the run");
    end
  end

endmodule
